// ==== compile.f ====
design/ptw_sv32_pkg.sv
design/ptw_if_pkg.sv
design/ptw_walk_fsm.sv
design/ptw_walk_ctx.sv
design/ptw_pte_check.sv
design/ptw_top.sv
verification/ptw_asserts.sv
verification/ptw_tb.sv

// ==== design/ptw_if_pkg.sv ====
package ptw_if_pkg;

  // --------------------------------------------------
  // memory port
  // --------------------------------------------------

  // word read request, held until granted
  typedef struct packed {
    logic                 req;
    ptw_sv32_pkg::paddr_t addr;
  } mem_req_t;

  // grant and read data strobes from the memory side
  // exactly one rvalid follows every grant
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // --------------------------------------------------
  // pte classification
  // --------------------------------------------------

  // one-hot verdict on the registered pte
  typedef struct packed {
    // v clear or write-only encoding
    logic invalid;
    // leaf that passes permission and alignment checks
    logic leaf_ok;
    // leaf that fails permission or alignment checks
    logic leaf_fault;
    // pointer into the next table level
    logic next_level;
    // pointer seen where only a leaf may appear
    logic last_level_ptr;
  } pte_verdict_t;

endpackage

// ==== design/ptw_pte_check.sv ====
`timescale 1ns/1ps

module ptw_pte_check (
  input  ptw_sv32_pkg::pte_t       pte_i,
  input  ptw_sv32_pkg::pt_level_t  level_i,
  input  logic                     is_instr_i,
  input  logic                     is_store_i,
  input  logic                     mxr_i,
  output ptw_if_pkg::pte_verdict_t verdict_o
);

  import ptw_sv32_pkg::*;

  // --------------------------------------------------
  // encoding
  // --------------------------------------------------

  logic pte_invalid;
  logic pte_leaf;
  logic at_last_level;

  // v clear, or the reserved write-only encoding
  assign pte_invalid   = !pte_i.v || (pte_i.w && !pte_i.r);
  // any of r or x makes the entry a leaf
  assign pte_leaf      = pte_i.r || pte_i.x;
  assign at_last_level = (level_i == pt_level_t'(PT_LEVELS - 1));

  // --------------------------------------------------
  // leaf checks
  // --------------------------------------------------

  logic instr_ok;
  logic load_ok;
  logic store_ok;
  logic perm_ok;
  logic misaligned;

  // fetch needs execute, accessed bit is managed by software
  assign instr_ok = pte_i.x && pte_i.a;
  // mxr lets loads read execute-only pages
  assign load_ok  = pte_i.a && (pte_i.r || (pte_i.x && mxr_i));
  // stores also need write and an already set dirty bit
  assign store_ok = load_ok && pte_i.w && pte_i.d;

  always_comb begin
    if (is_instr_i) begin
      perm_ok = instr_ok;
    end else if (is_store_i) begin
      perm_ok = store_ok;
    end else begin
      perm_ok = load_ok;
    end
  end

  // a 4 MiB superpage must have its low ppn slice clear
  assign misaligned = !at_last_level && (pte_i.ppn[VPN_PART_W-1:0] != '0);

  // --------------------------------------------------
  // verdict
  // --------------------------------------------------
  always_comb begin
    verdict_o                = '0;
    verdict_o.invalid        = pte_invalid;
    verdict_o.leaf_ok        = !pte_invalid && pte_leaf && perm_ok && !misaligned;
    verdict_o.leaf_fault     = !pte_invalid && pte_leaf && (!perm_ok || misaligned);
    verdict_o.next_level     = !pte_invalid && !pte_leaf && !at_last_level;
    verdict_o.last_level_ptr = !pte_invalid && !pte_leaf && at_last_level;
  end

endmodule

// ==== design/ptw_sv32_pkg.sv ====
package ptw_sv32_pkg;

  // --------------------------------------------------
  // sv32 geometry
  // --------------------------------------------------

  // 4 KiB pages
  localparam int unsigned PAGE_OFFSET_W = 12;
  // each level indexes 1024 entries of a page-sized table
  localparam int unsigned VPN_PART_W    = 10;
  // level 0 is the root table, level 1 the leaf table
  localparam int unsigned PT_LEVELS     = 2;
  localparam int unsigned PPN_W         = 22;
  // 22-bit ppn plus 12-bit offset
  localparam int unsigned PLEN          = PPN_W + PAGE_OFFSET_W;

  // --------------------------------------------------
  // address types
  // --------------------------------------------------

  typedef logic [31:0]                         vaddr_t;
  typedef logic [PLEN-1:0]                     paddr_t;
  typedef logic [PPN_W-1:0]                    ppn_t;
  typedef logic [VPN_PART_W*PT_LEVELS-1:0]     vpn_t;
  typedef logic [$clog2(PT_LEVELS)-1:0]        pt_level_t;

  // sv32 page-table entry, msb first
  typedef struct packed {
    ppn_t       ppn;
    // reserved for software, ignored by the walker
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

endpackage

// ==== design/ptw_top.sv ====
`timescale 1ns/1ps

module ptw_top #(
  parameter int unsigned ASID_W = 9
) (
  clk_i,
  rst_ni,
  flush_i,
  miss_i,
  satp_ppn_i,
  mxr_i,
  mem_rsp_i,
  mem_req_o,
  tlb_update_o,
  ptw_active_o,
  walking_instr_o,
  ptw_error_o,
  tlb_miss_o
);

  import ptw_sv32_pkg::*;
  import ptw_if_pkg::*;

  typedef logic [ASID_W-1:0] asid_t;

  typedef struct packed {
    logic   access;
    logic   hit;
    vaddr_t vaddr;
    asid_t  asid;
    logic   is_instr;
    logic   is_store;
  } miss_req_t;

  typedef struct packed {
    vaddr_t    vaddr;
    pt_level_t level;
    paddr_t    pptr;
    logic      global;
    logic      is_instr;
    logic      is_store;
    asid_t     asid;
  } walk_ctx_t;

  // refill entry for the shared tlb
  typedef struct packed {
    logic  valid;
    pte_t  content;
    vpn_t  vpn;
    asid_t asid;
    logic  is_superpage;
  } tlb_update_t;

  input  logic        clk_i;
  input  logic        rst_ni;
  input  logic        flush_i;
  input  miss_req_t   miss_i;
  input  ppn_t        satp_ppn_i;
  input  logic        mxr_i;
  input  mem_rsp_t    mem_rsp_i;
  output mem_req_t    mem_req_o;
  output tlb_update_t tlb_update_o;
  output logic        ptw_active_o;
  output logic        walking_instr_o;
  output logic        ptw_error_o;
  output logic        tlb_miss_o;

  // --------------------------------------------------
  // internal wiring
  // --------------------------------------------------

  logic         ctx_start;
  logic         ctx_descend;
  logic         update_valid;
  logic         mem_req;
  paddr_t       mem_addr;
  walk_ctx_t    ctx;
  pte_t         pte;
  logic         pte_valid;
  pte_verdict_t verdict;
  pte_t         leaf_pte;

  ptw_walk_fsm #(
    .ASID_W (ASID_W)
  ) i_walk_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .miss_i         (miss_i),
    .mem_gnt_i      (mem_rsp_i.gnt),
    .pte_valid_i    (pte_valid),
    .verdict_i      (verdict),
    .mem_req_o      (mem_req),
    .ctx_start_o    (ctx_start),
    .ctx_descend_o  (ctx_descend),
    .update_valid_o (update_valid),
    .ptw_active_o   (ptw_active_o),
    .ptw_error_o    (ptw_error_o),
    .tlb_miss_o     (tlb_miss_o)
  );

  ptw_walk_ctx #(
    .ASID_W (ASID_W)
  ) i_walk_ctx (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (ctx_start),
    .descend_i       (ctx_descend),
    .miss_i          (miss_i),
    .satp_ppn_i      (satp_ppn_i),
    .mem_rsp_i       (mem_rsp_i),
    .ctx_o           (ctx),
    .pte_o           (pte),
    .pte_valid_o     (pte_valid),
    .mem_addr_o      (mem_addr),
    .walking_instr_o (walking_instr_o)
  );

  ptw_pte_check i_pte_check (
    .pte_i      (pte),
    .level_i    (ctx.level),
    .is_instr_i (ctx.is_instr),
    .is_store_i (ctx.is_store),
    .mxr_i      (mxr_i),
    .verdict_o  (verdict)
  );

  assign mem_req_o = '{req: mem_req, addr: mem_addr};

  // --------------------------------------------------
  // tlb update
  // --------------------------------------------------

  // leaf pte with the global bit of the upper level folded in
  assign leaf_pte = '{ppn: pte.ppn, rsw: pte.rsw, d: pte.d, a: pte.a,
                      g: pte.g | ctx.global, u: pte.u, x: pte.x,
                      w: pte.w, r: pte.r, v: pte.v};

  // a leaf found at the root level maps a 4 MiB superpage
  assign tlb_update_o = '{valid:        update_valid,
                          content:      leaf_pte,
                          vpn:          ctx.vaddr[31:PAGE_OFFSET_W],
                          asid:         ctx.asid,
                          is_superpage: (ctx.level == pt_level_t'(0))};

endmodule

// ==== design/ptw_walk_ctx.sv ====
`timescale 1ns/1ps

module ptw_walk_ctx #(
  parameter int unsigned ASID_W = 9
) (
  clk_i,
  rst_ni,
  start_i,
  descend_i,
  miss_i,
  satp_ppn_i,
  mem_rsp_i,
  ctx_o,
  pte_o,
  pte_valid_o,
  mem_addr_o,
  walking_instr_o
);

  import ptw_sv32_pkg::*;
  import ptw_if_pkg::*;

  typedef logic [ASID_W-1:0] asid_t;

  typedef struct packed {
    logic   access;
    logic   hit;
    vaddr_t vaddr;
    asid_t  asid;
    logic   is_instr;
    logic   is_store;
  } miss_req_t;

  // state of the walk in progress
  typedef struct packed {
    vaddr_t    vaddr;
    pt_level_t level;
    paddr_t    pptr;
    logic      global;
    logic      is_instr;
    logic      is_store;
    asid_t     asid;
  } walk_ctx_t;

  input  logic      clk_i;
  input  logic      rst_ni;
  input  logic      start_i;
  input  logic      descend_i;
  input  miss_req_t miss_i;
  input  ppn_t      satp_ppn_i;
  input  mem_rsp_t  mem_rsp_i;
  output walk_ctx_t ctx_o;
  output pte_t      pte_o;
  output logic      pte_valid_o;
  output paddr_t    mem_addr_o;
  output logic      walking_instr_o;

  walk_ctx_t ctx_q;
  pte_t      pte_q;
  logic      pte_valid_q;

  // pte pointers, 4-byte stride into a page-sized table
  paddr_t root_pptr;
  paddr_t next_pptr;

  // root table from satp indexed by vpn[1]
  assign root_pptr = {satp_ppn_i,
                      miss_i.vaddr[PAGE_OFFSET_W+VPN_PART_W +: VPN_PART_W],
                      2'b00};
  // leaf table from the pointer pte indexed by vpn[0]
  assign next_pptr = {pte_q.ppn,
                      ctx_q.vaddr[PAGE_OFFSET_W +: VPN_PART_W],
                      2'b00};

  // --------------------------------------------------
  // walk context
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx_q       <= '0;
      pte_valid_q <= 1'b0;
    end else begin
      pte_valid_q <= mem_rsp_i.rvalid;
      if (start_i) begin
        ctx_q.vaddr    <= miss_i.vaddr;
        ctx_q.asid     <= miss_i.asid;
        ctx_q.is_instr <= miss_i.is_instr;
        ctx_q.is_store <= miss_i.is_store;
        ctx_q.level    <= '0;
        ctx_q.global   <= 1'b0;
        ctx_q.pptr     <= root_pptr;
      end else begin
        if (descend_i) begin
          ctx_q.level <= pt_level_t'(PT_LEVELS - 1);
          ctx_q.pptr  <= next_pptr;
        end
        // global sticks once any level of the walk marks it
        if (pte_valid_q) begin
          ctx_q.global <= ctx_q.global | pte_q.g;
        end
      end
    end
  end

  // response data, held until the next rvalid
  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) begin
      pte_q <= pte_t'(mem_rsp_i.rdata);
    end
  end

  assign ctx_o           = ctx_q;
  assign pte_o           = pte_q;
  assign pte_valid_o     = pte_valid_q;
  assign mem_addr_o      = ctx_q.pptr;
  assign walking_instr_o = ctx_q.is_instr;

endmodule

// ==== design/ptw_walk_fsm.sv ====
`timescale 1ns/1ps

module ptw_walk_fsm #(
  parameter int unsigned ASID_W = 9
) (
  clk_i,
  rst_ni,
  flush_i,
  miss_i,
  mem_gnt_i,
  pte_valid_i,
  verdict_i,
  mem_req_o,
  ctx_start_o,
  ctx_descend_o,
  update_valid_o,
  ptw_active_o,
  ptw_error_o,
  tlb_miss_o
);

  import ptw_sv32_pkg::*;
  import ptw_if_pkg::*;

  typedef logic [ASID_W-1:0] asid_t;

  // lookup request from the shared tlb
  typedef struct packed {
    logic   access;
    logic   hit;
    vaddr_t vaddr;
    asid_t  asid;
    logic   is_instr;
    logic   is_store;
  } miss_req_t;

  input  logic         clk_i;
  input  logic         rst_ni;
  input  logic         flush_i;
  input  miss_req_t    miss_i;
  input  logic         mem_gnt_i;
  input  logic         pte_valid_i;
  input  pte_verdict_t verdict_i;
  output logic         mem_req_o;
  output logic         ctx_start_o;
  output logic         ctx_descend_o;
  output logic         update_valid_o;
  output logic         ptw_active_o;
  output logic         ptw_error_o;
  output logic         tlb_miss_o;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR,
    LATENCY
  } walk_state_e;

  walk_state_e state_q, state_d;

  // a lookup that missed starts a walk
  logic miss_valid;
  // a response is still in flight and must be drained
  logic rsp_owed;

  assign miss_valid = miss_i.access && !miss_i.hit;
  assign rsp_owed   = ((state_q == WAIT_GRANT) && mem_gnt_i) ||
                      ((state_q inside {PTE_LOOKUP, WAIT_RVALID}) && !pte_valid_i);

  assign ptw_active_o = (state_q != IDLE);

  // --------------------------------------------------
  // next state and strobes
  // --------------------------------------------------
  always_comb begin
    state_d        = state_q;
    mem_req_o      = 1'b0;
    ctx_start_o    = 1'b0;
    ctx_descend_o  = 1'b0;
    update_valid_o = 1'b0;
    ptw_error_o    = 1'b0;
    tlb_miss_o     = 1'b0;

    case (state_q)
      IDLE: begin
        // context loads root pointer on this edge, req rises next cycle
        if (miss_valid && !flush_i) begin
          tlb_miss_o  = 1'b1;
          ctx_start_o = 1'b1;
          state_d     = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        // address comes straight from the context register, stable while held
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        // verdict is only meaningful while the registered response is valid
        if (pte_valid_i) begin
          if (verdict_i.leaf_ok) begin
            update_valid_o = 1'b1;
            state_d        = LATENCY;
          end else if (verdict_i.next_level) begin
            ctx_descend_o = 1'b1;
            state_d       = WAIT_GRANT;
          end else begin
            // invalid pte, leaf fault or pointer at the last level
            state_d = PROPAGATE_ERROR;
          end
        end
      end
      PROPAGATE_ERROR: begin
        ptw_error_o = 1'b1;
        state_d     = LATENCY;
      end
      WAIT_RVALID: begin
        // drain the response of an abandoned walk
        if (pte_valid_i) begin
          state_d = IDLE;
        end
      end
      LATENCY: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // --------------------------------------------------
    // flush
    // --------------------------------------------------
    // abandon the walk, but never leave a response unclaimed
    if (flush_i && (state_q != IDLE)) begin
      update_valid_o = 1'b0;
      ptw_error_o    = 1'b0;
      ctx_descend_o  = 1'b0;
      if (rsp_owed) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = LATENCY;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module ptw_tb \
  -f compile.f -o ptw_sim || { echo "build failed"; exit 1; }

./obj_dir/ptw_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verification/ptw_asserts.sv ====
`timescale 1ns/1ps

module ptw_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 flush_i,
  input ptw_if_pkg::mem_req_t mem_req_i,
  input logic                 gnt_i,
  input logic                 update_valid_i,
  input logic                 ptw_error_i,
  input logic                 tlb_miss_i,
  input logic                 ptw_active_i
);

  // failure count per rule
  int unsigned req_fails   = 0;
  int unsigned excl_fails  = 0;
  int unsigned reset_fails = 0;

  // --------------------------------------------------
  // memory request protocol
  // --------------------------------------------------

  // an ungranted request keeps req and its address
  // a flush may withdraw it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.req && !gnt_i && !flush_i |=> mem_req_i.req && $stable(mem_req_i.addr))
    else begin
      req_fails++;
      $error("request withdrawn or address changed before the grant");
    end

  // --------------------------------------------------
  // walk outcome
  // --------------------------------------------------

  // refill or error already seen in the current walk
  // cleared when the next miss is accepted
  logic outcome_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outcome_seen_q <= 1'b0;
    end else if (tlb_miss_i) begin
      outcome_seen_q <= 1'b0;
    end else if (update_valid_i || ptw_error_i) begin
      outcome_seen_q <= 1'b1;
    end
  end

  // a walk ends in exactly one refill or one error
  end_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (update_valid_i || ptw_error_i) |->
      !(update_valid_i && ptw_error_i) && !outcome_seen_q)
    else begin
      excl_fails++;
      $error("tlb update and error together, or a second outcome in one walk");
    end

  // all control outputs quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !mem_req_i.req && !update_valid_i && !ptw_error_i && !tlb_miss_i
                && !ptw_active_i)
    else begin
      reset_fails++;
      $error("control output active during reset");
    end

endmodule

// ==== verification/ptw_tb.sv ====
`timescale 1ns/1ps

module ptw_tb;

  import ptw_sv32_pkg::*;
  import ptw_if_pkg::*;

  localparam int unsigned ASID_W     = 9;
  localparam int unsigned WAIT_LIMIT = 200;

  typedef logic [ASID_W-1:0] asid_t;

  typedef struct packed {
    logic   access;
    logic   hit;
    vaddr_t vaddr;
    asid_t  asid;
    logic   is_instr;
    logic   is_store;
  } miss_req_t;

  typedef struct packed {
    logic  valid;
    pte_t  content;
    vpn_t  vpn;
    asid_t asid;
    logic  is_superpage;
  } tlb_update_t;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        mxr_i;
  miss_req_t   miss_i;
  ppn_t        satp_ppn_i;
  mem_rsp_t    mem_rsp_i;
  mem_req_t    mem_req_o;
  tlb_update_t tlb_update_o;
  logic        ptw_active_o;
  logic        walking_instr_o;
  logic        ptw_error_o;
  logic        tlb_miss_o;

  // page tables, one pte per word address
  logic [31:0] pte_mem [logic [31:0]];
  integer      seed = 5135;

  // pulse counts seen by the monitor
  int          n_update  = 0;
  int          n_error   = 0;
  int          n_miss    = 0;
  int          instr_bad = 0;
  tlb_update_t last_update;
  logic        cur_instr;
  int          errors = 0;

  ptw_top #(
    .ASID_W (ASID_W)
  ) DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .miss_i          (miss_i),
    .satp_ppn_i      (satp_ppn_i),
    .mxr_i           (mxr_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_req_o       (mem_req_o),
    .tlb_update_o    (tlb_update_o),
    .ptw_active_o    (ptw_active_o),
    .walking_instr_o (walking_instr_o),
    .ptw_error_o     (ptw_error_o),
    .tlb_miss_o      (tlb_miss_o)
  );

  bind ptw_top ptw_asserts u_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .mem_req_i      (mem_req_o),
    .gnt_i          (mem_rsp_i.gnt),
    .update_valid_i (update_valid),
    .ptw_error_i    (ptw_error_o),
    .tlb_miss_i     (tlb_miss_o),
    .ptw_active_i   (ptw_active_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------
  initial begin : mem_model
    int unsigned delay;
    logic [31:0] word_addr;
    mem_rsp_i = '0;
    forever begin
      @(negedge clk_i);
      mem_rsp_i.gnt    = 1'b0;
      mem_rsp_i.rvalid = 1'b0;
      if (mem_req_o.req) begin
        // grant after 0 to 3 cycles, given up when a flush drops req
        delay = $unsigned($random(seed)) % 4;
        while (delay > 0 && mem_req_o.req) begin
          @(negedge clk_i);
          delay--;
        end
        if (mem_req_o.req) begin
          word_addr     = mem_req_o.addr[PLEN-1:2];
          mem_rsp_i.gnt = 1'b1;
          @(negedge clk_i);
          mem_rsp_i.gnt = 1'b0;
          // read data 1 to 3 cycles after the grant
          delay = $unsigned($random(seed)) % 3;
          repeat (delay) @(negedge clk_i);
          mem_rsp_i.rvalid = 1'b1;
          mem_rsp_i.rdata  = pte_mem.exists(word_addr) ? pte_mem[word_addr] : 32'h0;
        end
      end
    end
  end

  // outputs are stable at the rising edge, inputs move on the falling one
  always @(posedge clk_i) begin
    if (tlb_update_o.valid) begin
      n_update++;
      last_update = tlb_update_o;
    end
    if (ptw_error_o) begin
      n_error++;
    end
    if (tlb_miss_o) begin
      n_miss++;
    end
    if (ptw_active_o && (walking_instr_o !== cur_instr)) begin
      instr_bad++;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("FAIL %s got %h exp %h", name, got, exp);
      end
  endtask

  // flags are {d, a, g, u, x, w, r, v}
  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    return pte_t'({ppn, 2'b00, flags});
  endfunction

  function automatic logic entry_bad(input pte_t p);
    return !p.v || (p.w && !p.r);
  endfunction

  // permission and alignment rules for a leaf at level lvl
  function automatic logic leaf_allowed(input pte_t p, input logic lvl, input logic instr,
                                        input logic store, input logic mxr);
    logic readable;
    readable = p.r || (mxr && p.x);
    if (!p.a || (!lvl && (p.ppn[9:0] != 10'h0))) begin
      return 1'b0;
    end
    if (instr) begin
      return p.x;
    end
    if (store) begin
      return readable && p.w && p.d;
    end
    return readable;
  endfunction

  task automatic wait_idle();
    int unsigned cycles;
    cycles = 0;
    while (ptw_active_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (ptw_active_o) begin
      errors++;
      $display("timeout, walker still active after %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic start_miss(input vaddr_t va, input asid_t asid, input logic instr,
                            input logic store);
    compare("ptw_active_o before miss", 64'(ptw_active_o), 64'(1'b0));
    miss_i    = '{access: 1'b1, hit: 1'b0, vaddr: va, asid: asid,
                  is_instr: instr, is_store: store};
    cur_instr = instr;
    @(negedge clk_i);
    miss_i.access = 1'b0;
  endtask

  // --------------------------------------------------
  // one complete walk with its predicted outcome
  // --------------------------------------------------
  task automatic walk(input vaddr_t va, input asid_t asid, input logic instr, input logic store,
                      input logic mxr, input pte_t root, input pte_t leaf);
    paddr_t root_addr;
    paddr_t leaf_addr;
    pte_t   exp_content;
    logic   exp_ok;
    logic   exp_super;
    int     upd0;
    int     err0;
    int     miss0;
    int     bad0;
    root_addr   = {satp_ppn_i, va[31:22], 2'b00};
    leaf_addr   = {root.ppn, va[21:12], 2'b00};
    exp_super   = 1'b0;
    exp_content = root;
    pte_mem[root_addr[PLEN-1:2]] = root;
    if (entry_bad(root)) begin
      exp_ok = 1'b0;
    end else if (root.r || root.x) begin
      exp_super = 1'b1;
      exp_ok    = leaf_allowed(root, 1'b0, instr, store, mxr);
    end else begin
      // pointer, the leaf table decides and g accumulates over both levels
      pte_mem[leaf_addr[PLEN-1:2]] = leaf;
      exp_content   = leaf;
      exp_content.g = leaf.g || root.g;
      exp_ok = !entry_bad(leaf) && (leaf.r || leaf.x) && leaf_allowed(leaf, 1'b1, instr,
                                                                      store, mxr);
    end
    upd0  = n_update;
    err0  = n_error;
    miss0 = n_miss;
    bad0  = instr_bad;
    mxr_i = mxr;
    start_miss(va, asid, instr, store);
    wait_idle();
    compare("tlb_update_o.valid pulses", 64'(n_update - upd0), 64'(exp_ok));
    compare("ptw_error_o pulses", 64'(n_error - err0), 64'(!exp_ok));
    compare("tlb_miss_o pulses", 64'(n_miss - miss0), 64'(1));
    compare("walking_instr_o mismatches", 64'(instr_bad - bad0), 64'(0));
    if (exp_ok) begin
      compare("tlb_update_o.content", 64'(last_update.content), 64'(exp_content));
      compare("tlb_update_o.vpn", 64'(last_update.vpn), 64'(va[31:12]));
      compare("tlb_update_o.asid", 64'(last_update.asid), 64'(asid));
      compare("tlb_update_o.is_superpage", 64'(last_update.is_superpage), 64'(exp_super));
    end
  endtask

  // walk abandoned before the grant, or after it while rvalid is owed
  task automatic flushed_walk(input vaddr_t va, input pte_t root, input logic late);
    paddr_t      root_addr;
    int          upd0;
    int          err0;
    int unsigned cycles;
    root_addr = {satp_ppn_i, va[31:22], 2'b00};
    pte_mem[root_addr[PLEN-1:2]] = root;
    upd0   = n_update;
    err0   = n_error;
    cycles = 0;
    start_miss(va, 9'h055, 1'b0, 1'b0);
    if (late) begin
      do begin
        @(posedge clk_i);
        cycles++;
      end while (!mem_rsp_i.gnt && cycles < WAIT_LIMIT);
      @(negedge clk_i);
    end else begin
      while (!mem_req_o.req && cycles < WAIT_LIMIT) begin
        @(negedge clk_i);
        cycles++;
      end
    end
    if (cycles >= WAIT_LIMIT) begin
      errors++;
      $display("timeout, no memory request or grant before the flush");
    end
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    wait_idle();
    compare("tlb_update_o.valid after flush", 64'(n_update - upd0), 64'(0));
    compare("ptw_error_o after flush", 64'(n_error - err0), 64'(0));
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    int unsigned assert_fails;
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    mxr_i      = 1'b0;
    satp_ppn_i = 22'h00100;
    miss_i     = '0;
    cur_instr  = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // 4 KiB pages, the first through a global root pointer
    walk(32'h00401abc, 9'h1a5, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h21),
         make_pte(22'h12345, 8'hc7));
    walk(32'h00802abc, 9'h003, 1'b0, 1'b1, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h2abcd, 8'hc7));
    walk(32'h00c03abc, 9'h0f0, 1'b1, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h33333, 8'h4b));
    // superpages, aligned then misaligned
    walk(32'h01004abc, 9'h111, 1'b0, 1'b0, 1'b0, make_pte(22'h00c00, 8'h63), '0);
    walk(32'h01405abc, 9'h112, 1'b0, 1'b0, 1'b0, make_pte(22'h00c05, 8'h43), '0);
    // fetch without x, store with d clear, a clear
    walk(32'h01806abc, 9'h020, 1'b1, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00abc, 8'h43));
    walk(32'h01c07abc, 9'h021, 1'b0, 1'b1, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00abc, 8'h47));
    walk(32'h02008abc, 9'h022, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00abc, 8'h83));
    // execute-only page loaded without and with mxr
    walk(32'h02409abc, 9'h023, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00def, 8'h49));
    walk(32'h0280aabc, 9'h024, 1'b0, 1'b0, 1'b1, make_pte(22'h00200, 8'h01),
         make_pte(22'h00def, 8'h49));
    // invalid root, write-only leaf, pointer at the last level
    walk(32'h02c0babc, 9'h030, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h00), '0);
    walk(32'h0300cabc, 9'h031, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00abc, 8'h45));
    walk(32'h0340dabc, 9'h032, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h00300, 8'h01));

    // flush while waiting for the grant, then for the response
    flushed_walk(32'h0380eabc, make_pte(22'h00200, 8'h01), 1'b0);
    walk(32'h03c0fabc, 9'h040, 1'b1, 1'b0, 1'b0, make_pte(22'h00200, 8'h01),
         make_pte(22'h01234, 8'h4b));
    flushed_walk(32'h04010abc, make_pte(22'h00200, 8'h01), 1'b1);
    walk(32'h00401abc, 9'h041, 1'b0, 1'b0, 1'b0, make_pte(22'h00200, 8'h21),
         make_pte(22'h12345, 8'hc7));

    assert_fails = DUT.u_asserts.req_fails + DUT.u_asserts.excl_fails +
                   DUT.u_asserts.reset_fails;
    $display("errors: %0d testbench checks, %0d assertions", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
